//--- src.f
common/chnl_pkg.sv
common/msa_pkg.sv
src/seq_ram.sv
rx_loader/rx_loader.sv
pair_scorer/pair_scorer.sv
src/tx_sender.sv
src/chnl_tester.sv
verification/chnl_tester_properties.sv
verification/tb_chnl_tester.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_chnl_tester
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+100

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_chnl_tester.sv
`timescale 1ns/100ps

module tb_chnl_tester;

	// largest run and longest sequence used by any test
	localparam int MAX_P = 20;
	localparam int MAX_L = 16;
	localparam int RUN_A = 8;
	localparam int RUN_B = 3;
	// rx and tx words per test
	localparam int WORDS_T2 = 1 + 1 + 8 + 1;
	localparam int WORDS_T3 = 1 + 2 + 7 + 2;
	localparam int WORDS_T4 = 1 + MAX_P * (1 + MAX_L) + MAX_P;
	localparam int WORDS_T5 = 2 + (RUN_A + RUN_B) * (2 + MAX_L);
	localparam int CYCLE_LIMIT = 4 * (WORDS_T2 + WORDS_T3 + WORDS_T4 + WORDS_T5) + 200;

	logic CLK = 1'b0;
	logic RST;
	chnl_pkg::chnl_rx_t chnl_rx;
	logic rx_ack;
	logic rx_ren;
	chnl_pkg::chnl_tx_t chnl_tx;
	logic tx_ack;
	logic tx_ren;

	// pair model refilled per run
	int len1 [MAX_P];
	int len2 [MAX_P];
	logic [msa_pkg::ACID_W-1:0] acid1 [MAX_P][MAX_L];
	logic [msa_pkg::ACID_W-1:0] acid2 [MAX_P][MAX_L];

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int stalls = 0;
	int cycle_cnt = 0;

	chnl_tester chnl_tester_inst (
		.CLK(CLK),
		.RST(RST),
		.chnl_rx_i(chnl_rx),
		.chnl_rx_ack_o(rx_ack),
		.chnl_rx_data_ren_o(rx_ren),
		.chnl_tx_o(chnl_tx),
		.chnl_tx_ack_i(tx_ack),
		.chnl_tx_data_ren_i(tx_ren)
	);

	always #2 CLK = ~CLK;

	// hard stop
	always @(posedge CLK) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, DUT never finished the test", cycle_cnt);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ============================================================
	// compare tasks
	// ============================================================

	task automatic check_score(input string name, input logic [msa_pkg::SCORE_W-1:0] got,
		input logic [msa_pkg::SCORE_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_len(input string name, input logic [chnl_pkg::LEN_W-1:0] got,
		input logic [chnl_pkg::LEN_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// ============================================================
	// model and word builders
	// ============================================================

	// equal acids below the shorter length
	function automatic logic [msa_pkg::SCORE_W-1:0] expected_score(input int p);
		logic [msa_pkg::SCORE_W-1:0] cnt;
		int shorter;
		cnt = '0;
		shorter = (len1[p] < len2[p]) ? len1[p] : len2[p];
		for (int i = 0; i < shorter; i++) begin
			if (acid1[p][i] == acid2[p][i]) begin
				cnt = cnt + 1'b1;
			end
		end
		return cnt;
	endfunction

	function automatic int longer(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// seq1 length at 30:22, seq2 length at 20:12
	function automatic logic [31:0] length_word(input int l1, input int l2);
		return (32'(l1) << 22) | (32'(l2) << 12);
	endfunction

	// seq1 acid at 10:6, seq2 acid at 4:0
	function automatic logic [31:0] acid_word(input logic [4:0] a1, input logic [4:0] a2);
		return {21'b0, a1, 1'b0, a2};
	endfunction

	// about half the positions match
	task automatic fill_random(input int n);
		for (int p = 0; p < n; p++) begin
			len1[p] = $urandom_range(0, MAX_L);
			len2[p] = $urandom_range(0, MAX_L);
			for (int i = 0; i < MAX_L; i++) begin
				acid1[p][i] = 5'($urandom_range(0, 25));
				acid2[p][i] = ($urandom_range(0, 1) == 1) ? acid1[p][i] :
					5'($urandom_range(0, 25));
			end
		end
	endtask

	// ============================================================
	// channel drivers called at edge plus 1 ns
	// ============================================================

	// ren only depends on registers, so it is settled here
	task automatic send_word(input logic [31:0] w);
		chnl_rx.data = w;
		chnl_rx.data_valid = 1'b1;
		while (!rx_ren) begin
			stalls++;
			@(posedge CLK);
			#1;
		end
		@(posedge CLK);
		#1;
	endtask

	task automatic send_run(input int n);
		int total;
		total = 1;
		for (int p = 0; p < n; p++) begin
			total += 1 + longer(len1[p], len2[p]);
		end
		chnl_rx.rx = 1'b1;
		chnl_rx.last = 1'b1;
		chnl_rx.off = '0;
		chnl_rx.len = 32'(total);
		@(posedge CLK);
		#1;
		check_bit("chnl_rx_ack_o before header", rx_ack, 1'b1);
		send_word(32'(n));
		check_bit("chnl_rx_ack_o after header", rx_ack, 1'b0);
		stalls = 0;
		for (int p = 0; p < n; p++) begin
			send_word(length_word(len1[p], len2[p]));
			for (int i = 0; i < longer(len1[p], len2[p]); i++) begin
				send_word(acid_word(acid1[p][i], acid2[p][i]));
			end
		end
		chnl_rx.data_valid = 1'b0;
		chnl_rx.rx = 1'b0;
	endtask

	// take n scores in order with random or steady ren
	task automatic collect_scores(input int n, input bit rand_ren);
		int got_cnt;
		got_cnt = 0;
		while (!chnl_tx.tx) begin
			@(posedge CLK);
			#1;
		end
		check_len("chnl_tx.len", chnl_tx.len, 32'(n));
		tx_ack = 1'b1;
		while (got_cnt < n) begin
			tx_ren = rand_ren ? 1'($urandom_range(0, 1)) : 1'b1;
			if (chnl_tx.data_valid && tx_ren) begin
				check_score($sformatf("score[%0d]", got_cnt),
					chnl_tx.data[msa_pkg::SCORE_W-1:0], expected_score(got_cnt));
				check_bit("chnl_tx.data upper bits", |chnl_tx.data[31:msa_pkg::SCORE_W], 1'b0);
				got_cnt++;
			end
			@(posedge CLK);
			#1;
			tx_ack = 1'b0;
		end
		tx_ren = 1'b0;
		// tx drops right after the last word
		check_bit("chnl_tx.tx after last word", chnl_tx.tx, 1'b0);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_before);
		end
	endtask

	// ============================================================
	// tests
	// ============================================================

	task automatic reset_values();
		int e;
		e = errors;
		check_bit("chnl_rx_ack_o", rx_ack, 1'b0);
		check_bit("chnl_rx_data_ren_o", rx_ren, 1'b0);
		check_bit("chnl_tx.tx", chnl_tx.tx, 1'b0);
		check_bit("chnl_tx.data_valid", chnl_tx.data_valid, 1'b0);
		finish_test("reset_values", e);
	endtask

	// matches at 0, 3 and 6
	task automatic single_pair();
		int e;
		e = errors;
		len1[0] = 8;
		len2[0] = 8;
		for (int i = 0; i < 8; i++) begin
			acid1[0][i] = 5'(i + 3);
			acid2[0][i] = (i % 3 == 0) ? acid1[0][i] : 5'(i + 12);
		end
		send_run(1);
		collect_scores(1, 1'b0);
		finish_test("single_pair", e);
	endtask

	// tail past 4 made equal so counting it would overshoot
	task automatic unequal_lengths();
		int e;
		e = errors;
		len1[0] = 7;
		len2[0] = 4;
		for (int i = 0; i < 7; i++) begin
			acid1[0][i] = 5'(i + 1);
			acid2[0][i] = (i % 2 == 0 || i >= 4) ? acid1[0][i] : 5'(20);
		end
		len1[1] = 0;
		len2[1] = 0;
		send_run(2);
		collect_scores(2, 1'b0);
		finish_test("unequal_lengths", e);
	endtask

	task automatic ping_pong_burst();
		int e;
		e = errors;
		fill_random(MAX_P);
		send_run(MAX_P);
		check_bit("rx back-pressure seen", stalls != 0, 1'b1);
		collect_scores(MAX_P, 1'b0);
		finish_test("ping_pong_burst", e);
	endtask

	// second run must land at index 0 again
	task automatic random_ren_rerun();
		int e;
		e = errors;
		fill_random(RUN_A);
		send_run(RUN_A);
		collect_scores(RUN_A, 1'b1);
		fill_random(RUN_B);
		send_run(RUN_B);
		collect_scores(RUN_B, 1'b1);
		finish_test("random_ren_rerun", e);
	endtask

	initial begin
		void'($urandom(93));
		RST = 1'b1;
		chnl_rx = '0;
		tx_ack = 1'b0;
		tx_ren = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		RST = 1'b0;
		reset_values();
		single_pair();
		unequal_lengths();
		ping_pong_burst();
		random_ren_rerun();
		errors += chnl_tester_inst.chnl_tester_properties_inst.fail_cnt;
		$display("tests %0d, failed %0d, errors %0d, cycles %0d",
			tests_run, tests_failed, errors, cycle_cnt);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- verification/chnl_tester_properties.sv
`timescale 1ns/100ps

module chnl_tester_properties (
	input logic CLK,
	input logic RST,
	input logic chnl_rx_data_ren_o,
	input chnl_pkg::chnl_tx_t chnl_tx_o
);

	// failed assertions, read by the testbench summary
	int fail_cnt = 0;

	// ============================================================
	// transmit framing
	// ============================================================

	// no data outside a transaction
	tx_valid_in_tx: assert property (@(posedge CLK) disable iff (RST)
		chnl_tx_o.data_valid |-> chnl_tx_o.tx)
		else begin
			fail_cnt++;
			$error("tx data_valid high while tx is low");
		end

	// one transaction, always last, never offset
	tx_last_no_off: assert property (@(posedge CLK) disable iff (RST)
		chnl_tx_o.tx |-> (chnl_tx_o.last && chnl_tx_o.off == '0))
		else begin
			fail_cnt++;
			$error("tx high without last or with a nonzero offset");
		end

	// loader idle right out of reset
	ren_low_after_rst: assert property (@(posedge CLK)
		RST |=> !chnl_rx_data_ren_o)
		else begin
			fail_cnt++;
			$error("rx data ren high in the cycle after reset");
		end

endmodule

bind chnl_tester chnl_tester_properties chnl_tester_properties_inst (
	.CLK(CLK),
	.RST(RST),
	.chnl_rx_data_ren_o(chnl_rx_data_ren_o),
	.chnl_tx_o(chnl_tx_o)
);

//--- src/chnl_tester.sv
`timescale 1ns/100ps

module chnl_tester (
	input  logic CLK,
	input  logic RST,
	input  chnl_pkg::chnl_rx_t chnl_rx_i,
	output logic chnl_rx_ack_o,
	output logic chnl_rx_data_ren_o,
	output chnl_pkg::chnl_tx_t chnl_tx_o,
	input  logic chnl_tx_ack_i,
	input  logic chnl_tx_data_ren_i
);

	// tx ack is not needed, the sender only follows ren

	// loader to scorer and sender
	msa_pkg::run_info_t run;
	// ping-pong pair buffers
	logic [1:0] buf_wr_en;
	logic [msa_pkg::BUF_ADDR_W-1:0] buf_wr_addr;
	msa_pkg::acid_pair_t buf_wr_data;
	logic [msa_pkg::BUF_ADDR_W-1:0] buf_rd_addr;
	msa_pkg::acid_pair_t [1:0] buf_rd_data;
	// bank handshake
	logic [1:0] bank_full;
	logic [1:0] bank_release;
	msa_pkg::seq_lengths_t [1:0] bank_lengths;
	// score path
	msa_pkg::score_wr_t score_wr;
	logic [msa_pkg::PAIR_IDX_W-1:0] score_rd_addr;
	logic [msa_pkg::SCORE_W-1:0] score_rd_data;

	rx_loader rx_loader_inst (
		.CLK(CLK),
		.RST(RST),
		.chnl_rx_i(chnl_rx_i),
		.chnl_rx_ack_o(chnl_rx_ack_o),
		.chnl_rx_data_ren_o(chnl_rx_data_ren_o),
		.run_o(run),
		.buf_wr_en_o(buf_wr_en),
		.buf_wr_addr_o(buf_wr_addr),
		.buf_wr_data_o(buf_wr_data),
		.bank_full_o(bank_full),
		.bank_lengths_o(bank_lengths),
		.bank_release_i(bank_release)
	);

	// bank 0 and bank 1 share write data and read address
	for (genvar b = 0; b < 2; b++) begin : g_bank
		seq_ram #(
			.DATA_W($bits(msa_pkg::acid_pair_t)),
			.ADDR_W(msa_pkg::BUF_ADDR_W)
		) pair_buf_inst (
			.CLK(CLK),
			.wr_en_i(buf_wr_en[b]),
			.wr_addr_i(buf_wr_addr),
			.wr_data_i(buf_wr_data),
			.rd_addr_i(buf_rd_addr),
			.rd_data_o(buf_rd_data[b])
		);
	end

	pair_scorer pair_scorer_inst (
		.CLK(CLK),
		.RST(RST),
		.run_i(run),
		.bank_full_i(bank_full),
		.bank_lengths_i(bank_lengths),
		.buf_rd_addr_o(buf_rd_addr),
		.buf_rd_data_i(buf_rd_data),
		.bank_release_o(bank_release),
		.score_wr_o(score_wr)
	);

	// one score per pair, indexed by pair number
	seq_ram #(
		.DATA_W(msa_pkg::SCORE_W),
		.ADDR_W(msa_pkg::PAIR_IDX_W)
	) score_mem_inst (
		.CLK(CLK),
		.wr_en_i(score_wr.we),
		.wr_addr_i(score_wr.idx),
		.wr_data_i(score_wr.score),
		.rd_addr_i(score_rd_addr),
		.rd_data_o(score_rd_data)
	);

	tx_sender tx_sender_inst (
		.CLK(CLK),
		.RST(RST),
		.run_i(run),
		.score_wr_i(score_wr),
		.score_rd_addr_o(score_rd_addr),
		.score_rd_data_i(score_rd_data),
		.chnl_tx_o(chnl_tx_o),
		.chnl_tx_data_ren_i(chnl_tx_data_ren_i)
	);

endmodule

//--- src/tx_sender.sv
`timescale 1ns/100ps

module tx_sender (
	input  logic CLK,
	input  logic RST,
	input  msa_pkg::run_info_t run_i,
	input  msa_pkg::score_wr_t score_wr_i,
	output logic [msa_pkg::PAIR_IDX_W-1:0] score_rd_addr_o,
	input  logic [msa_pkg::SCORE_W-1:0] score_rd_data_i,
	output chnl_pkg::chnl_tx_t chnl_tx_o,
	input  logic chnl_tx_data_ren_i
);

	chnl_pkg::sender_state_e state_q;
	logic [msa_pkg::PAIR_CNT_W-1:0] num_pairs_q;
	logic [msa_pkg::PAIR_CNT_W-1:0] fin_cnt_q;
	logic [msa_pkg::PAIR_IDX_W-1:0] addr_q;
	logic armed_q;
	logic tx_fire;
	logic last_word;

	assign tx_fire = (state_q == chnl_pkg::TX_SEND) && chnl_tx_data_ren_i;
	assign last_word = ({1'b0, addr_q} + 1'b1 == num_pairs_q);

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state_q <= chnl_pkg::TX_IDLE;
			num_pairs_q <= '0;
			fin_cnt_q <= '0;
			addr_q <= '0;
			armed_q <= 1'b0;
		end else begin
			case (state_q)
				chnl_pkg::TX_IDLE: begin
					// all scores of this run are in memory
					if (armed_q && fin_cnt_q == num_pairs_q) begin
						armed_q <= 1'b0;
						addr_q <= '0;
						state_q <= chnl_pkg::TX_FETCH;
					end
				end
				chnl_pkg::TX_FETCH: begin
					state_q <= chnl_pkg::TX_SEND;
				end
				chnl_pkg::TX_SEND: begin
					// address held, so data stays put while ren is low
					if (tx_fire) begin
						if (last_word) begin
							state_q <= chnl_pkg::TX_IDLE;
						end else begin
							addr_q <= addr_q + 1'b1;
							state_q <= chnl_pkg::TX_FETCH;
						end
					end
				end
				default: begin
					state_q <= chnl_pkg::TX_IDLE;
				end
			endcase
			// count finished scores
			if (run_i.start) begin
				fin_cnt_q <= '0;
				num_pairs_q <= run_i.num_pairs;
				armed_q <= 1'b1;
			end else if (score_wr_i.we) begin
				fin_cnt_q <= fin_cnt_q + 1'b1;
			end
		end
	end

	assign score_rd_addr_o = addr_q;

	// single transaction, always last, no offset
	always_comb begin
		chnl_tx_o = '0;
		chnl_tx_o.tx = (state_q != chnl_pkg::TX_IDLE);
		chnl_tx_o.last = 1'b1;
		chnl_tx_o.len[msa_pkg::PAIR_CNT_W-1:0] = num_pairs_q;
		chnl_tx_o.data[msa_pkg::SCORE_W-1:0] = score_rd_data_i;
		chnl_tx_o.data_valid = (state_q == chnl_pkg::TX_SEND);
	end

endmodule

//--- pair_scorer/pair_scorer.sv
`timescale 1ns/100ps

module pair_scorer (
	input  logic CLK,
	input  logic RST,
	input  msa_pkg::run_info_t run_i,
	input  logic [1:0] bank_full_i,
	input  msa_pkg::seq_lengths_t [1:0] bank_lengths_i,
	output logic [msa_pkg::BUF_ADDR_W-1:0] buf_rd_addr_o,
	input  msa_pkg::acid_pair_t [1:0] buf_rd_data_i,
	output logic [1:0] bank_release_o,
	output msa_pkg::score_wr_t score_wr_o
);

	msa_pkg::scorer_state_e state_q;
	logic rbank_q;
	logic [msa_pkg::PAIR_IDX_W-1:0] pair_idx_q;
	logic [msa_pkg::SEQ_LEN_W-1:0] rd_cnt_q;
	logic [msa_pkg::SEQ_LEN_W-1:0] rd_idx_q;
	logic [msa_pkg::SEQ_LEN_W-1:0] max_len_q;
	logic [msa_pkg::SEQ_LEN_W-1:0] min_len_q;
	logic [msa_pkg::SEQ_LEN_W-1:0] max_len;
	logic [msa_pkg::SEQ_LEN_W-1:0] min_len;
	logic rd_vld_q;
	logic [msa_pkg::SCORE_W-1:0] match_q;
	msa_pkg::seq_lengths_t len_sel;
	msa_pkg::acid_pair_t pair_sel;
	logic start_pair;
	logic hit;
	logic wr_fire;

	// current bank only
	assign len_sel = bank_lengths_i[rbank_q];
	assign pair_sel = buf_rd_data_i[rbank_q];
	assign max_len = (len_sel.seq1_len > len_sel.seq2_len) ? len_sel.seq1_len : len_sel.seq2_len;
	assign min_len = (len_sel.seq1_len > len_sel.seq2_len) ? len_sel.seq2_len : len_sel.seq1_len;
	assign start_pair = (state_q == msa_pkg::SC_IDLE) && bank_full_i[rbank_q];

	// ============================================================
	// compare stage, one cycle behind the read
	// ============================================================

	// tail past the shorter sequence is read but never counted
	assign hit = rd_vld_q && (rd_idx_q < min_len_q) && (pair_sel.seq1 == pair_sel.seq2);
	// write waits until the last compare has landed in match_q
	assign wr_fire = (state_q == msa_pkg::SC_WRITE) && !rd_vld_q;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state_q <= msa_pkg::SC_IDLE;
			rbank_q <= 1'b0;
			pair_idx_q <= '0;
			rd_cnt_q <= '0;
			rd_vld_q <= 1'b0;
			match_q <= '0;
		end else begin
			rd_vld_q <= (state_q == msa_pkg::SC_READ);
			if (hit) begin
				match_q <= match_q + 1'b1;
			end
			case (state_q)
				msa_pkg::SC_IDLE: begin
					if (start_pair) begin
						rd_cnt_q <= '0;
						match_q <= '0;
						// empty pair skips straight to the score write
						state_q <= (max_len == '0) ? msa_pkg::SC_WRITE : msa_pkg::SC_READ;
					end
				end
				msa_pkg::SC_READ: begin
					rd_cnt_q <= rd_cnt_q + 1'b1;
					if (rd_cnt_q == max_len_q - 1'b1) begin
						state_q <= msa_pkg::SC_WRITE;
					end
				end
				msa_pkg::SC_WRITE: begin
					if (wr_fire) begin
						rbank_q <= ~rbank_q;
						pair_idx_q <= pair_idx_q + 1'b1;
						state_q <= msa_pkg::SC_IDLE;
					end
				end
				default: begin
					state_q <= msa_pkg::SC_IDLE;
				end
			endcase
			// new run scores from index 0
			if (run_i.start) begin
				pair_idx_q <= '0;
			end
		end
	end

	// pair lengths and index pipe
	always_ff @(posedge CLK) begin
		rd_idx_q <= rd_cnt_q;
		if (start_pair) begin
			max_len_q <= max_len;
			min_len_q <= min_len;
		end
	end

	assign buf_rd_addr_o = rd_cnt_q;
	assign bank_release_o = wr_fire ? (rbank_q ? 2'b10 : 2'b01) : 2'b00;
	assign score_wr_o.we = wr_fire;
	assign score_wr_o.idx = pair_idx_q;
	assign score_wr_o.score = match_q;

endmodule

//--- rx_loader/rx_loader.sv
`timescale 1ns/100ps

module rx_loader (
	input  logic CLK,
	input  logic RST,
	input  chnl_pkg::chnl_rx_t chnl_rx_i,
	output logic chnl_rx_ack_o,
	output logic chnl_rx_data_ren_o,
	output msa_pkg::run_info_t run_o,
	output logic [1:0] buf_wr_en_o,
	output logic [msa_pkg::BUF_ADDR_W-1:0] buf_wr_addr_o,
	output msa_pkg::acid_pair_t buf_wr_data_o,
	output logic [1:0] bank_full_o,
	output msa_pkg::seq_lengths_t [1:0] bank_lengths_o,
	input  logic [1:0] bank_release_i
);

	chnl_pkg::loader_state_e state_q;
	chnl_pkg::loader_state_e state_d;
	logic [chnl_pkg::DATA_W-1:0] word;
	logic [msa_pkg::HDR_PAIRS_MSB-msa_pkg::HDR_PAIRS_LSB:0] hdr_field;
	logic [msa_pkg::PAIR_CNT_W-1:0] hdr_pairs;
	logic [msa_pkg::PAIR_CNT_W-1:0] num_pairs_q;
	logic [msa_pkg::PAIR_CNT_W-1:0] pair_cnt_q;
	logic [msa_pkg::SEQ_LEN_W-1:0] acid_cnt_q;
	logic [msa_pkg::SEQ_LEN_W-1:0] max_len;
	msa_pkg::seq_lengths_t len_word;
	msa_pkg::seq_lengths_t len_q;
	msa_pkg::seq_lengths_t len_cur;
	msa_pkg::seq_lengths_t [1:0] lengths_q;
	logic [1:0] full_q;
	logic wbank_q;
	logic start_q;
	logic rx_fire;
	logic acid_fire;
	logic pair_done;
	logic last_pair;

	// ============================================================
	// word decode
	// ============================================================

	assign word = chnl_rx_i.data;
	assign hdr_field = word[msa_pkg::HDR_PAIRS_MSB:msa_pkg::HDR_PAIRS_LSB];
	// host caps the count, upper header bits dropped
	assign hdr_pairs = hdr_field[msa_pkg::PAIR_CNT_W-1:0];
	assign len_word.seq1_len = word[msa_pkg::LEN1_MSB:msa_pkg::LEN1_LSB];
	assign len_word.seq2_len = word[msa_pkg::LEN2_MSB:msa_pkg::LEN2_LSB];
	assign buf_wr_data_o.seq1 = word[msa_pkg::ACID1_MSB:msa_pkg::ACID1_LSB];
	assign buf_wr_data_o.seq2 = word[msa_pkg::ACID2_MSB:msa_pkg::ACID2_LSB];

	// lengths straight off the bus while the length word is on it
	assign len_cur = (state_q == chnl_pkg::LD_LENGTH) ? len_word : len_q;
	assign max_len = (len_cur.seq1_len > len_cur.seq2_len) ? len_cur.seq1_len : len_cur.seq2_len;
	assign last_pair = (pair_cnt_q + 1'b1 == num_pairs_q);

	// back-pressure on acids only, target bank still being scored
	assign chnl_rx_data_ren_o = (state_q == chnl_pkg::LD_HEADER) ||
		(state_q == chnl_pkg::LD_LENGTH) ||
		(state_q == chnl_pkg::LD_ACIDS && !full_q[wbank_q] && max_len != '0);
	assign rx_fire = chnl_rx_i.data_valid && chnl_rx_data_ren_o;
	assign acid_fire = (state_q == chnl_pkg::LD_ACIDS) && rx_fire;

	// empty pair completes on its length word, or later once its bank frees up
	assign pair_done = !full_q[wbank_q] &&
		((state_q == chnl_pkg::LD_LENGTH && rx_fire && max_len == '0) ||
		(state_q == chnl_pkg::LD_ACIDS &&
		(max_len == '0 || (rx_fire && acid_cnt_q == max_len - 1'b1))));

	// ============================================================
	// FSM
	// ============================================================

	always_comb begin
		state_d = state_q;
		case (state_q)
			chnl_pkg::LD_IDLE: begin
				if (chnl_rx_i.rx) begin
					state_d = chnl_pkg::LD_HEADER;
				end
			end
			chnl_pkg::LD_HEADER: begin
				if (rx_fire) begin
					state_d = (hdr_pairs == '0) ? chnl_pkg::LD_DONE : chnl_pkg::LD_LENGTH;
				end
			end
			chnl_pkg::LD_LENGTH: begin
				if (rx_fire) begin
					state_d = chnl_pkg::LD_ACIDS;
				end
			end
			chnl_pkg::LD_DONE: begin
				state_d = chnl_pkg::LD_IDLE;
			end
			default: begin
				state_d = state_q;
			end
		endcase
		// end of a pair overrides the above
		if (pair_done) begin
			state_d = last_pair ? chnl_pkg::LD_DONE : chnl_pkg::LD_LENGTH;
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state_q <= chnl_pkg::LD_IDLE;
			start_q <= 1'b0;
			num_pairs_q <= '0;
			pair_cnt_q <= '0;
			acid_cnt_q <= '0;
			wbank_q <= 1'b0;
			full_q <= '0;
		end else begin
			state_q <= state_d;
			start_q <= (state_q == chnl_pkg::LD_HEADER) && rx_fire;
			full_q <= full_q & ~bank_release_i;
			if (state_q == chnl_pkg::LD_HEADER && rx_fire) begin
				num_pairs_q <= hdr_pairs;
				pair_cnt_q <= '0;
			end
			if (state_q == chnl_pkg::LD_LENGTH && rx_fire) begin
				acid_cnt_q <= '0;
			end else if (acid_fire) begin
				acid_cnt_q <= acid_cnt_q + 1'b1;
			end
			// hand the bank to the scorer, move to the other one
			if (pair_done) begin
				full_q[wbank_q] <= 1'b1;
				wbank_q <= ~wbank_q;
				pair_cnt_q <= pair_cnt_q + 1'b1;
			end
		end
	end

	// lengths held until the bank is handed over
	always_ff @(posedge CLK) begin
		if (state_q == chnl_pkg::LD_LENGTH && rx_fire) begin
			len_q <= len_word;
		end
		if (pair_done) begin
			lengths_q[wbank_q] <= len_cur;
		end
	end

	assign chnl_rx_ack_o = (state_q == chnl_pkg::LD_HEADER);
	assign run_o.start = start_q;
	assign run_o.num_pairs = num_pairs_q;
	assign buf_wr_en_o = acid_fire ? (wbank_q ? 2'b10 : 2'b01) : 2'b00;
	assign buf_wr_addr_o = acid_cnt_q;
	assign bank_full_o = full_q;
	assign bank_lengths_o = lengths_q;

endmodule

//--- src/seq_ram.sv
`timescale 1ns/100ps

module seq_ram #(
	parameter int DATA_W = 10,
	parameter int ADDR_W = 9
) (
	input  logic CLK,
	input  logic wr_en_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  logic [DATA_W-1:0] wr_data_i,
	input  logic [ADDR_W-1:0] rd_addr_i,
	output logic [DATA_W-1:0] rd_data_o
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// write port
	always_ff @(posedge CLK) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// read port, one cycle latency, reads every cycle
	always_ff @(posedge CLK) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

//--- common/msa_pkg.sv
package msa_pkg;

	// ============================================================
	// sizes
	// ============================================================

	// 26 amino acid codes fit in 5 bits
	localparam int ACID_W = 5;
	localparam int SEQ_LEN_W = 9;
	// pair buffer depth, one acid pair per word
	localparam int BUF_ADDR_W = 9;
	localparam int MAX_PAIRS = 1024;
	// score memory address
	localparam int PAIR_IDX_W = 10;
	// pair count, one bit wider so MAX_PAIRS fits
	localparam int PAIR_CNT_W = PAIR_IDX_W + 1;
	localparam int SCORE_W = 16;

	// ============================================================
	// word fields
	// ============================================================

	// header word
	localparam int HDR_PAIRS_MSB = 17;
	localparam int HDR_PAIRS_LSB = 0;
	// length word
	localparam int LEN1_MSB = 30;
	localparam int LEN1_LSB = 22;
	localparam int LEN2_MSB = 20;
	localparam int LEN2_LSB = 12;
	// acid word
	localparam int ACID1_MSB = 10;
	localparam int ACID1_LSB = 6;
	localparam int ACID2_MSB = 4;
	localparam int ACID2_LSB = 0;

	// one buffer word
	typedef struct packed {
		logic [ACID_W-1:0] seq1;
		logic [ACID_W-1:0] seq2;
	} acid_pair_t;

	typedef struct packed {
		logic [SEQ_LEN_W-1:0] seq1_len;
		logic [SEQ_LEN_W-1:0] seq2_len;
	} seq_lengths_t;

	// start pulses once per receive transaction
	typedef struct packed {
		logic start;
		logic [PAIR_CNT_W-1:0] num_pairs;
	} run_info_t;

	typedef struct packed {
		logic we;
		logic [PAIR_IDX_W-1:0] idx;
		logic [SCORE_W-1:0] score;
	} score_wr_t;

	typedef enum logic [1:0] {
		SC_IDLE,
		SC_READ,
		SC_WRITE
	} scorer_state_e;

endpackage

//--- common/chnl_pkg.sv
package chnl_pkg;

	// ============================================================
	// channel widths
	// ============================================================

	// one channel word
	localparam int DATA_W = 32;
	// transaction length in words
	localparam int LEN_W = 32;
	// offset in words, never used by this design
	localparam int OFF_W = 31;

	// ============================================================
	// channel bundles
	// ============================================================

	// receive side, every field driven by the host
	typedef struct packed {
		logic rx;
		logic last;
		logic [LEN_W-1:0] len;
		logic [OFF_W-1:0] off;
		logic [DATA_W-1:0] data;
		logic data_valid;
	} chnl_rx_t;

	// transmit side, every field driven by the design
	typedef struct packed {
		logic tx;
		logic last;
		logic [LEN_W-1:0] len;
		logic [OFF_W-1:0] off;
		logic [DATA_W-1:0] data;
		logic data_valid;
	} chnl_tx_t;

	// receive parser
	typedef enum logic [2:0] {
		LD_IDLE,
		LD_HEADER,
		LD_LENGTH,
		LD_ACIDS,
		LD_DONE
	} loader_state_e;

	// score streamer
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_FETCH,
		TX_SEND
	} sender_state_e;

endpackage
